/* logic/decode_stage.sv */
`timescale 1ns/100ps
`include "rv32_config.svh"

// instruction register, field split, immediate build and alu decode
// id_ex is combinational from the instruction register
module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  logic [`XLEN-1:0]      inst,
    input  rv32_pkg::result_t     ex_fwd,
    input  rv32_pkg::result_t     mem_fwd,
    input  rv32_pkg::result_t     wb_fwd,
    output rv32_pkg::dec_bundle_t id_ex
);

    logic [`XLEN-1:0]       inst_q;
    logic                   inst_vld;
    rv32_pkg::opcode_e      opcode;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`XLEN-1:0]       imm;
    logic                   supported;
    rv32_pkg::alu_fun_e     alu_fun;
    logic [`XLEN-1:0]       rf_rs1_data;
    logic [`XLEN-1:0]       rf_rs2_data;
    logic [`XLEN-1:0]       op1_val;
    logic [`XLEN-1:0]       op2_val;

    // accept every valid word, no ready
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            inst_q <= inst;
        end
        if (reset) begin
            inst_vld <= 1'b0;
        end else begin
            inst_vld <= inst_valid;
        end
    end

    // standard rv32 field positions
    assign opcode = rv32_pkg::opcode_e'(inst_q[6:0]);
    assign rd     = inst_q[11:7];
    assign funct3 = inst_q[14:12];
    assign rs1    = inst_q[19:15];
    assign rs2    = inst_q[24:20];
    assign funct7 = inst_q[31:25];
    // I-immediate, sign from bit 31
    assign imm    = {{(`XLEN-12){inst_q[31]}}, inst_q[31:20]};

    // alu function from opcode, funct3 and funct7
    always_comb begin
        supported = 1'b1;
        alu_fun   = rv32_pkg::ALU_ADD;
        case (funct3)
            3'd0: begin
                // sub only exists in the register form
                if (opcode == rv32_pkg::OPC_OP && funct7[5]) begin
                    alu_fun = rv32_pkg::ALU_SUB;
                end
            end
            3'd1: alu_fun = rv32_pkg::ALU_SLL;
            3'd2: alu_fun = rv32_pkg::ALU_SLT;
            3'd3: alu_fun = rv32_pkg::ALU_SLTU;
            3'd4: alu_fun = rv32_pkg::ALU_XOR;
            3'd5: begin
                // sra and srai both flag themselves in bit 30
                if (funct7[5]) begin
                    alu_fun = rv32_pkg::ALU_SRA;
                end else begin
                    alu_fun = rv32_pkg::ALU_SRL;
                end
            end
            3'd6: alu_fun = rv32_pkg::ALU_OR;
            default: alu_fun = rv32_pkg::ALU_AND;
        endcase
        case (opcode)
            rv32_pkg::OPC_OP, rv32_pkg::OPC_OP_IMM: supported = 1'b1;
            // anything else travels on as a bubble
            default: supported = 1'b0;
        endcase
    end

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .wr       (wb_fwd)
    );

    // one bypass mux per source
    operand_forward u_fwd_rs1 (
        .src     (rs1),
        .rf_data (rf_rs1_data),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .value   (op1_val)
    );

    operand_forward u_fwd_rs2 (
        .src     (rs2),
        .rf_data (rf_rs2_data),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd),
        .value   (op2_val)
    );

    always_comb begin
        id_ex.valid   = inst_vld && supported;
        id_ex.rd      = rd;
        id_ex.rs1     = rs1;
        id_ex.rs2     = rs2;
        id_ex.alu_fun = alu_fun;
        id_ex.use_imm = (opcode == rv32_pkg::OPC_OP_IMM);
        id_ex.imm     = imm;
        id_ex.op1     = op1_val;
        id_ex.op2     = op2_val;
    end

    // execute trusts alu_fun blindly, so a valid bundle
    // must never reach it with an unknown or out-of-range code
    a_legal_alu_fun: assert property (
        @(posedge clk) disable iff (reset)
        id_ex.valid |-> !$isunknown(id_ex.alu_fun)
            && (id_ex.alu_fun inside {[rv32_pkg::ALU_ADD : rv32_pkg::ALU_SLTU]})
    ) else $error("decode_stage: valid bundle with illegal alu_fun");

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/100ps
`include "rv32_config.svh"

// ID/EX register and the alu
// ex_fwd is combinational from the register and also feeds
// the bypass muxes in decode
module execute_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  rv32_pkg::dec_bundle_t id_ex,
    output rv32_pkg::result_t     ex_fwd
);

    rv32_pkg::dec_bundle_t ex_q;
    logic [`XLEN-1:0]      op_a;
    logic [`XLEN-1:0]      op_b;
    logic [4:0]            shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;
    logic [`XLEN-1:0]      alu_out;

    // payload follows the bundle every cycle, valid has the reset
    always_ff @(posedge clk) begin
        ex_q <= id_ex;
        if (reset) begin
            ex_q.valid <= 1'b0;
        end
    end

    // operand 2 mux, imm for OP-IMM
    assign op_a  = ex_q.op1;
    assign op_b  = ex_q.use_imm ? ex_q.imm : ex_q.op2;
    // shift amount, low five bits only
    assign shamt = op_b[4:0];

    // compares for slt and sltu
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (ex_q.alu_fun)
            rv32_pkg::ALU_ADD: begin
                alu_out = op_a + op_b;
            end
            rv32_pkg::ALU_SUB: begin
                alu_out = op_a - op_b;
            end
            rv32_pkg::ALU_SLL: begin
                alu_out = op_a << shamt;
            end
            rv32_pkg::ALU_SRL: begin
                alu_out = op_a >> shamt;
            end
            rv32_pkg::ALU_SRA: begin
                // true arithmetic shift, sign bit fills from the left
                alu_out = $unsigned($signed(op_a) >>> shamt);
            end
            rv32_pkg::ALU_AND: begin
                alu_out = op_a & op_b;
            end
            rv32_pkg::ALU_OR: begin
                alu_out = op_a | op_b;
            end
            rv32_pkg::ALU_XOR: begin
                alu_out = op_a ^ op_b;
            end
            rv32_pkg::ALU_SLT: begin
                alu_out = {{(`XLEN-1){1'b0}}, lt_signed};
            end
            rv32_pkg::ALU_SLTU: begin
                alu_out = {{(`XLEN-1){1'b0}}, lt_unsigned};
            end
            default: begin
                // unreachable for valid bundles
                alu_out = '0;
            end
        endcase
    end

    // result tap, also the input of the MEM register
    assign ex_fwd.valid = ex_q.valid;
    assign ex_fwd.rd    = ex_q.rd;
    assign ex_fwd.data  = alu_out;

endmodule

/* logic/operand_forward.sv */
`timescale 1ns/100ps
`include "rv32_config.svh"

// bypass mux for one source register
// newest producer wins: execute, then memory, then writeback,
// and the register file only when no stage in flight targets src
module operand_forward (
    input  logic [`REG_ADDR_W-1:0] src,
    input  logic [`XLEN-1:0]       rf_data,
    input  rv32_pkg::result_t      ex_fwd,
    input  rv32_pkg::result_t      mem_fwd,
    input  rv32_pkg::result_t      wb_fwd,
    output logic [`XLEN-1:0]       value
);

    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    // a producer counts only when valid and writing a real register
    // bubbles and rd == x0 results never forward
    assign ex_hit  = ex_fwd.valid && (ex_fwd.rd != '0) && (ex_fwd.rd == src);
    assign mem_hit = mem_fwd.valid && (mem_fwd.rd != '0) && (mem_fwd.rd == src);
    assign wb_hit  = wb_fwd.valid && (wb_fwd.rd != '0) && (wb_fwd.rd == src);

    always_comb begin
        if (src == '0) begin
            // x0 source, always zero
            value = '0;
        end else if (ex_hit) begin
            // producer directly ahead, alu output this cycle
            value = ex_fwd.data;
        end else if (mem_hit) begin
            // two ahead
            value = mem_fwd.data;
        end else if (wb_hit) begin
            // three ahead, rf write lands on the next edge
            value = wb_fwd.data;
        end else begin
            // no hazard
            value = rf_data;
        end
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/100ps
`include "rv32_config.svh"

// integer register file
// two combinational read ports, one synchronous write port
module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    input  rv32_pkg::result_t      wr
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             wr_en;

    // writes to x0 are dropped here
    assign wr_en = wr.valid && (wr.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            // every register reads zero after reset
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // x0 hard-wired to zero on both ports
    // a write shows up here on the cycle after its edge
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // entry zero holds its reset value for the whole run,
    // even when retire hands over results with rd == x0
    a_x0_never_written: assert property (
        @(posedge clk) disable iff (reset)
        regs[0] == '0
    ) else $error("reg_file: entry x0 was written");

endmodule

/* logic/retire_stage.sv */
`timescale 1ns/100ps

// MEM and WB registers
// no memory access here, the result only moves along
// mem_fwd and wb_fwd double as bypass taps for decode
module retire_stage (
    input  logic              clk,
    input  logic              reset,
    input  rv32_pkg::result_t ex_fwd,
    output rv32_pkg::result_t mem_fwd,
    output rv32_pkg::result_t wb_fwd
);

    // two register levels, valid bits reset, data does not
    always_ff @(posedge clk) begin
        // memory stage
        mem_fwd <= ex_fwd;
        // writeback stage, drives rf write and retire port
        wb_fwd  <= mem_fwd;
        if (reset) begin
            mem_fwd.valid <= 1'b0;
            wb_fwd.valid  <= 1'b0;
        end
    end

    // retire valid gates both the rf write and the external port
    // an X here would corrupt state and the retire stream
    a_wb_valid_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(wb_fwd.valid)
    ) else $error("retire_stage: wb_fwd.valid is unknown");

endmodule

/* logic/rv32_alu_pipe.sv */
`timescale 1ns/100ps
`include "rv32_config.svh"

// five-stage rv32i alu pipeline
// fetch is the inst/inst_valid input, then decode, execute, mem, wb
// an instruction taken at edge k retires at edge k+3
module rv32_alu_pipe (
    input  logic              clk,
    input  logic              reset,
    input  logic              inst_valid,
    input  logic [`XLEN-1:0]  inst,
    output rv32_pkg::result_t retire
);

    // decode to execute
    rv32_pkg::dec_bundle_t id_ex;
    // alu result, combinational in execute
    rv32_pkg::result_t     ex_fwd;
    // registered results in MEM and WB
    rv32_pkg::result_t     mem_fwd;
    rv32_pkg::result_t     wb_fwd;

    // holds reg_file and both bypass muxes
    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .id_ex      (id_ex)
    );

    execute_stage u_execute (
        .clk    (clk),
        .reset  (reset),
        .id_ex  (id_ex),
        .ex_fwd (ex_fwd)
    );

    retire_stage u_retire (
        .clk     (clk),
        .reset   (reset),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .wb_fwd  (wb_fwd)
    );

    // wb result goes out as the retire port
    // rd == x0 results still retire with their computed data
    assign retire = wb_fwd;

endmodule

/* logic/rv32_config.svh */
`ifndef RV32_CONFIG_SVH
`define RV32_CONFIG_SVH

// architectural word width
`define XLEN 32

// number of integer registers, x0 included
`define NUM_REGS 32

// bits needed to index one register
`define REG_ADDR_W 5

// rd, rs1 and rs2 all use the same index width,
// so any change here must keep 2**REG_ADDR_W == NUM_REGS

`endif

/* logic/rv32_pkg.sv */
`include "rv32_config.svh"

package rv32_pkg;

    // major opcodes handled by the pipeline
    // everything else is turned into a bubble in decode
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // alu function codes
    // numbering kept in the order the pipeline team has always used
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SRL  = 4'd3,
        ALU_SRA  = 4'd4,
        ALU_AND  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_fun_e;

    // decoded instruction, handed from decode to execute
    typedef struct packed {
        // cleared for idle cycles and unsupported opcodes
        logic                   valid;
        // destination and source indices
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        // operation for the alu
        alu_fun_e               alu_fun;
        // operand 2 from imm instead of op2
        logic                   use_imm;
        // sign-extended I-immediate
        logic [`XLEN-1:0]       imm;
        // source values after forwarding
        logic [`XLEN-1:0]       op1;
        logic [`XLEN-1:0]       op2;
    } dec_bundle_t;

    // one produced value with its destination
    // used for the forwarding taps, the rf write and the retire port
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } result_t;

endpackage

/* rv32_alu_pipe.f */
+incdir+logic
logic/rv32_pkg.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/retire_stage.sv
logic/rv32_alu_pipe.sv
tests/rv32_alu_pipe_tb.sv

/* tests/rv32_alu_pipe_tb.sv */
`timescale 1ns/100ps
`include "rv32_config.svh"

module rv32_alu_pipe_tb;

    // stimulus lengths, one slot per falling edge
    localparam int RESET_CYCLES = 8;
    localparam int N_RANDOM     = 300;
    localparam int N_DENSE      = 400;
    localparam int N_X0         = 40;
    localparam int N_MIX        = 300;
    // reset, idle gap, seeding, x0 pairs, readback, drains and margin
    localparam int INST_COUNT   = RESET_CYCLES + 11 + 31 + N_RANDOM + N_DENSE
                                  + 2 * N_X0 + N_MIX + `NUM_REGS + 6 * 5 + 6;
    localparam int WATCHDOG_CYCLES = INST_COUNT * 4 + 50;

    logic              clk = 1'b0;
    logic              reset;
    logic              inst_valid;
    logic [`XLEN-1:0]  inst;
    rv32_pkg::result_t retire;

    // architectural model state
    logic [`XLEN-1:0]  model_regs [`NUM_REGS];
    rv32_pkg::result_t exp_q [$];
    // edge at which each expected result should show on retire
    int                due_q [$];
    int                cycle = 0;
    int                retired = 0;
    string             test_name = "reset";

    rv32_alu_pipe uut (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .retire     (retire)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // rising edges seen so far
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // failure line, then the fail message, then stop
    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(input rv32_pkg::result_t exp, input rv32_pkg::result_t act);
        if (exp !== act) begin
            abort_run($sformatf(
                "[FAIL] %s: expected valid=%b rd=%0d data=%h, actual valid=%b rd=%0d data=%h",
                test_name, exp.valid, exp.rd, exp.data, act.valid, act.rd, act.data));
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (exp != act) begin
            abort_run($sformatf("[FAIL] %s: expected retire at edge %0d, actual edge %0d",
                                test_name, exp, act));
        end
    endtask

    // rv32i encoders
    function automatic logic [31:0] enc_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm12, rs1, f3, rd, rv32_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv32_pkg::OPC_OP};
    endfunction

    // legal OP or OP-IMM word, registers drawn from x0..x(max_reg)
    function automatic logic [31:0] rand_alu_inst(input int max_reg);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [6:0]  f7;
        rd    = 5'($urandom % (max_reg + 1));
        rs1   = 5'($urandom % (max_reg + 1));
        rs2   = 5'($urandom % (max_reg + 1));
        f3    = 3'($urandom % 8);
        imm12 = 12'($urandom % 4096);
        if ($urandom % 2 == 0) begin
            // shift immediates carry only shamt, plus bit 10 for srai
            if (f3 == 3'd1) begin
                imm12 = {7'b0, imm12[4:0]};
            end else if (f3 == 3'd5) begin
                imm12 = {1'b0, imm12[10], 5'b0, imm12[4:0]};
            end
            return enc_i(imm12, rs1, f3, rd);
        end
        // funct7 bit 5 only for sub and sra
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1)) ? 7'h20 : 7'h00;
        return enc_r(f7, rs2, rs1, f3, rd);
    endfunction

    // any word whose opcode is neither OP nor OP-IMM
    function automatic logic [31:0] rand_bad_inst();
        logic [31:0] w;
        w = $urandom;
        if (w[6:0] == rv32_pkg::OPC_OP || w[6:0] == rv32_pkg::OPC_OP_IMM) begin
            // load opcode
            w[6:0] = 7'h03;
        end
        return w;
    endfunction

    // architectural execution of one word, in program order
    task automatic execute_model(input logic [31:0] w, output rv32_pkg::result_t r,
                                 output logic ok);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] y;
        opc = w[6:0];
        f3  = w[14:12];
        ok  = (opc == rv32_pkg::OPC_OP) || (opc == rv32_pkg::OPC_OP_IMM);
        a   = model_regs[w[19:15]];
        b   = (opc == rv32_pkg::OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        sh  = b[4:0];
        case (f3)
            3'd0: y = (opc == rv32_pkg::OPC_OP && w[30]) ? a - b : a + b;
            3'd1: y = a << sh;
            // signed compare by flipping both sign bits
            3'd2: y = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            3'd3: y = {31'b0, a < b};
            3'd4: y = a ^ b;
            3'd5: begin
                y = a >> sh;
                // arithmetic form refills vacated bits with the sign
                if (w[30] && a[31]) begin
                    y = y | ~(32'hffff_ffff >> sh);
                end
            end
            3'd6: y = a | b;
            default: y = a & b;
        endcase
        r.valid = 1'b1;
        r.rd    = w[11:7];
        r.data  = y;
        // x0 keeps zero, its result still retires
        if (ok && w[11:7] != 5'd0) begin
            model_regs[w[11:7]] = y;
        end
    endtask

    // drive one slot on the falling edge, model it if it will be accepted
    task automatic issue(input logic v, input logic [31:0] word);
        rv32_pkg::result_t r;
        logic              ok;
        @(negedge clk);
        inst_valid = v;
        inst       = word;
        if (v) begin
            execute_model(word, r, ok);
            if (ok) begin
                exp_q.push_back(r);
                // accepted at the next edge, retires three edges later
                due_q.push_back(cycle + 4);
            end
        end
    endtask

    // idle until every expected result has retired
    task automatic drain();
        @(negedge clk);
        inst_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // retire monitor, sampled mid-cycle where retire is stable
    always @(negedge clk) begin
        rv32_pkg::result_t exp_r;
        int                due;
        if (!reset) begin
            if ($isunknown(retire.valid)) begin
                abort_run("retire.valid is unknown after reset");
            end else if (retire.valid) begin
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("%s: a result retired with no instruction outstanding",
                                        test_name));
                end else begin
                    exp_r = exp_q.pop_front();
                    due   = due_q.pop_front();
                    check_result(exp_r, retire);
                    check_latency(due, cycle);
                    retired++;
                end
            end
        end
    end

    // watchdog, sized from the stimulus length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before the stimulus finished");
    end

    initial begin
        void'($urandom(22));
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // quiet pipeline, then a single instruction for latency
        test_name = "reset_latency";
        repeat (10) issue(1'b0, $urandom);
        issue(1'b1, enc_i(12'd5, 5'd0, 3'd0, 5'd1));
        drain();

        // seed every register with a random signed value, then mix all ops
        test_name = "random_alu";
        for (int i = 1; i < `NUM_REGS; i++) begin
            issue(1'b1, enc_i(12'($urandom % 4096), 5'($urandom % 32), 3'd0, 5'(i)));
        end
        repeat (N_RANDOM) issue(1'b1, rand_alu_inst(31));
        drain();

        // x0..x3 only, so almost every source hits a stage in flight
        test_name = "forward_dense";
        repeat (N_DENSE) issue(1'b1, rand_alu_inst(3));
        drain();

        // write x0, then read it straight back into x2
        test_name = "x0_writes";
        repeat (N_X0) begin
            issue(1'b1, rand_alu_inst(7) & 32'hffff_f07f);
            issue(1'b1, enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd2));
        end
        drain();

        // idle slots and unsupported opcodes in between
        test_name = "bubbles_mix";
        repeat (N_MIX) begin
            case ($urandom % 8)
                0, 1: issue(1'b0, $urandom);
                2: issue(1'b1, rand_bad_inst());
                default: issue(1'b1, rand_alu_inst(7));
            endcase
        end
        drain();

        // copy each register into x1, x1 itself first and x0 last
        test_name = "reg_readback";
        for (int i = 1; i <= `NUM_REGS; i++) begin
            issue(1'b1, enc_i(12'd0, 5'(i % `NUM_REGS), 3'd0, 5'd1));
        end
        drain();

        // a few spare cycles to catch stray retires
        repeat (6) @(negedge clk);
        $display("retired %0d instructions", retired);
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected results never retired", exp_q.size()));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule
